/* alu/alu_booth_mul.sv */
`default_nettype none

module alu_booth_mul (
  input  wire logic                         clock,
  input  wire logic                         reset,
  input  wire logic                         start,
  input  wire logic [alu_pkg::DATA_W-1:0]   multiplicand,
  input  wire logic [alu_pkg::DATA_W-1:0]   multiplier,
  output logic                              done,
  output logic      [alu_pkg::RESULT_W-1:0] product
);

  localparam int W = alu_pkg::DATA_W;

  logic         run;
  logic [3:0]   count;
  logic [W+1:0] mcand;    // Sign extended by two bits
  logic [W+1:0] acc;
  logic [W:0]   mq;       // {multiplier, q-1}
  logic [W+1:0] pp;
  logic [W+1:0] sum;

  // Radix-4 recoding of three multiplier bits
  always_comb begin
    case (mq[2:0])
      3'b001, 3'b010: pp = mcand;
      3'b011:         pp = mcand << 1;
      3'b100:         pp = -(mcand << 1);
      3'b101, 3'b110: pp = -mcand;
      default:        pp = '0;
    endcase
    sum = acc + pp;
  end

  assign product = {acc[W-1:0], mq[W:1]};

  always_ff @(posedge clock) begin
    if (reset) begin
      run   <= 1'b0;
      count <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        run   <= 1'b1;
        count <= '0;
      end else if (run) begin
        count <= count + 4'd1;
        if (count == 4'd15) begin
          run  <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      mcand <= {{2{multiplicand[W-1]}}, multiplicand};
      acc   <= '0;
      mq    <= {multiplier, 1'b0};
    end else if (run) begin
      acc <= {{2{sum[W+1]}}, sum[W+1:2]}; // Arithmetic shift by two
      mq  <= {sum[1:0], mq[W:2]};
    end
  end

endmodule

`default_nettype wire

/* alu/alu_divider.sv */
`default_nettype none

module alu_divider (
  input  wire logic                       clock,
  input  wire logic                       reset,
  input  wire logic                       start,
  input  wire logic [alu_pkg::DATA_W-1:0] dividend,
  input  wire logic [alu_pkg::DATA_W-1:0] divisor,
  output logic                            done,
  output logic      [alu_pkg::DATA_W-1:0] quotient,
  output logic      [alu_pkg::DATA_W-1:0] remainder
);

  localparam int W = alu_pkg::DATA_W;

  logic         run;
  logic [4:0]   count;
  logic [W-1:0] rem_q;
  logic [W-1:0] quo_q;    // Dividend magnitude shifts out, quotient in
  logic [W-1:0] dvs_q;
  logic         qneg_q;
  logic         rneg_q;   // Remainder follows dividend sign
  logic         zero_q;
  logic [W:0]   shifted;
  logic [W:0]   diff;
  logic [W-1:0] rem_next;
  logic [W-1:0] quo_next;

  // One restoring step
  always_comb begin
    shifted  = {rem_q, quo_q[W-1]};
    diff     = shifted - {1'b0, dvs_q};
    rem_next = diff[W] ? shifted[W-1:0] : diff[W-1:0];
    quo_next = {quo_q[W-2:0], ~diff[W]};
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      run   <= 1'b0;
      count <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        run   <= 1'b1;
        count <= '0;
      end else if (run) begin
        count <= count + 5'd1;
        if (count == 5'd31) begin
          run  <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      rem_q  <= '0;
      quo_q  <= dividend[W-1] ? -dividend : dividend;
      dvs_q  <= divisor[W-1] ? -divisor : divisor;
      qneg_q <= dividend[W-1] ^ divisor[W-1];
      rneg_q <= dividend[W-1];
      zero_q <= (divisor == '0);
    end else if (run) begin
      rem_q <= rem_next;
      quo_q <= quo_next;
      if (count == 5'd31) begin
        // Zero divisor leaves |a| in the remainder, so only the quotient is forced
        quotient  <= zero_q ? '1 : (qneg_q ? -quo_next : quo_next);
        remainder <= rneg_q ? -rem_next : rem_next;
      end
    end
  end

endmodule

`default_nettype wire

/* alu/alu_logic_arith.sv */
`default_nettype none

module alu_logic_arith (
  input  wire logic [alu_pkg::DATA_W-1:0] a,
  input  wire logic [alu_pkg::DATA_W-1:0] b,
  output logic      [alu_pkg::DATA_W-1:0] and_out,
  output logic      [alu_pkg::DATA_W-1:0] or_out,
  output logic      [alu_pkg::DATA_W-1:0] add_out,
  output logic      [alu_pkg::DATA_W-1:0] sub_out,
  output logic      [alu_pkg::DATA_W-1:0] neg_out,
  output logic      [alu_pkg::DATA_W-1:0] not_out,
  output logic      [alu_pkg::DATA_W-1:0] inc_out
);

  localparam int W = alu_pkg::DATA_W;

  // Adder with carry in that every arithmetic output is built on
  function automatic logic [W-1:0] add_cin(
    input logic [W-1:0] x,
    input logic [W-1:0] y,
    input logic         cin
  );
    return x + y + {{(W-1){1'b0}}, cin};
  endfunction

  always_comb begin
    and_out = a & b;
    or_out  = a | b;
    not_out = ~b;
    add_out = add_cin(a, b, 1'b0);
    sub_out = add_cin(a, ~b, 1'b1);   // a + ~b + 1
    neg_out = add_cin('0, ~b, 1'b1);  // Two's complement of b
    inc_out = add_cin(a, '0, 1'b1);   // PC + 1
  end

endmodule

`default_nettype wire

/* alu/alu_shifter.sv */
`default_nettype none

module alu_shifter (
  input  wire logic [alu_pkg::DATA_W-1:0] a,
  input  wire logic [4:0]                 amount,
  input  wire alu_pkg::shift_op_e         sel,
  output logic      [alu_pkg::DATA_W-1:0] shift_out
);

  localparam int W = alu_pkg::DATA_W;

  logic [5:0][W-1:0] stage;
  logic              left;
  logic              rot;
  logic              fill;

  // Left ops run through the right-shift muxes on a bit-reversed word
  always_comb begin
    int src;
    left = (sel == alu_pkg::sh_shl) || (sel == alu_pkg::sh_rol);
    rot  = (sel == alu_pkg::sh_ror) || (sel == alu_pkg::sh_rol);
    fill = (sel == alu_pkg::sh_shra) && a[W-1]; // Sign fill only for shra
    for (int j = 0; j < W; j++) begin
      stage[0][j] = left ? a[W-1-j] : a[j];
    end
    for (int s = 0; s < 5; s++) begin
      for (int j = 0; j < W; j++) begin
        src = j + (1 << s);
        if (!amount[s]) begin
          stage[s+1][j] = stage[s][j];
        end else if (src < W || rot) begin
          stage[s+1][j] = stage[s][src % W]; // Wraps for rotates
        end else begin
          stage[s+1][j] = fill;
        end
      end
    end
    for (int j = 0; j < W; j++) begin
      shift_out[j] = left ? stage[5][W-1-j] : stage[5][j];
    end
  end

endmodule

`default_nettype wire

/* common/alu_pkg.sv */
`default_nettype none

package alu_pkg;

  localparam int DATA_W = 32;
  localparam int RESULT_W = 64; // {hi, lo}

  typedef enum logic [4:0] {
    op_add  = 5'b00011,
    op_sub  = 5'b00100,
    op_shr  = 5'b00101,
    op_shra = 5'b00110,
    op_shl  = 5'b00111,
    op_ror  = 5'b01000,
    op_rol  = 5'b01001,
    op_and  = 5'b01010,
    op_or   = 5'b01011,
    op_mul  = 5'b01111,
    op_div  = 5'b10000,
    op_neg  = 5'b10001,
    op_not  = 5'b10010,
    op_nop  = 5'b11010
  } alu_op_e;

  typedef struct packed {
    alu_op_e             op;
    logic                inc_pc; // Overrides op
    logic [DATA_W-1:0]   a;
    logic [DATA_W-1:0]   b;
  } alu_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] hi;
    logic [DATA_W-1:0] lo;
  } alu_result_t;

  typedef enum logic [2:0] {sh_shr, sh_shra, sh_shl, sh_ror, sh_rol} shift_op_e;

endpackage

`default_nettype wire

/* compile.f */
+incdir+sim
common/alu_pkg.sv
alu/alu_logic_arith.sv
alu/alu_shifter.sv
alu/alu_booth_mul.sv
alu/alu_divider.sv
verilog/alu_unit.sv
sim/tb_alu_unit.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module tb_alu_unit -o tb_alu_unit
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/tb_alu_unit)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "ALL CHECKS PASSED"; then
  exit 0
fi
exit 1

/* sim/alu_vectors.svh */
`ifndef ALU_VECTORS_SVH
`define ALU_VECTORS_SVH

// Each row holds op, inc_pc, a, b and expect_ignore
// A row with expect_ignore set is pulsed while the divide row above it is busy
localparam vec_t DIRECTED [38] = '{
  '{alu_pkg::op_add,  1'b0, 32'h0000_0005, 32'h0000_0007, 1'b0},
  '{alu_pkg::op_add,  1'b0, 32'hffff_ffff, 32'h0000_0001, 1'b0}, // Wraps to zero
  '{alu_pkg::op_sub,  1'b0, 32'h0000_0003, 32'h0000_000a, 1'b0},
  '{alu_pkg::op_sub,  1'b0, 32'h8000_0000, 32'h0000_0001, 1'b0},
  '{alu_pkg::op_and,  1'b0, 32'hf0f0_ff00, 32'h0ff0_f0f0, 1'b0},
  '{alu_pkg::op_or,   1'b0, 32'hf0f0_0000, 32'h0000_0f0f, 1'b0},
  '{alu_pkg::op_neg,  1'b0, 32'h0000_1234, 32'h0000_0005, 1'b0},
  '{alu_pkg::op_neg,  1'b0, 32'h0000_0000, 32'h8000_0000, 1'b0},
  '{alu_pkg::op_not,  1'b0, 32'h0000_0000, 32'ha5a5_0ff0, 1'b0},
  '{alu_pkg::op_shr,  1'b0, 32'h8000_0001, 32'h0000_0001, 1'b0},
  '{alu_pkg::op_shra, 1'b0, 32'h8000_0010, 32'h0000_0004, 1'b0},
  '{alu_pkg::op_shra, 1'b0, 32'h8000_0000, 32'h0000_001f, 1'b0},
  '{alu_pkg::op_shl,  1'b0, 32'h0000_0001, 32'h0000_001f, 1'b0},
  '{alu_pkg::op_shl,  1'b0, 32'h1234_5678, 32'h0000_0000, 1'b0},
  '{alu_pkg::op_ror,  1'b0, 32'h1234_5678, 32'h0000_0008, 1'b0},
  '{alu_pkg::op_rol,  1'b0, 32'h1234_5678, 32'h0000_0004, 1'b0},
  '{alu_pkg::op_ror,  1'b0, 32'h8765_4321, 32'hffff_ffe5, 1'b0}, // Only b[4:0] counts
  '{alu_pkg::op_mul,  1'b0, 32'h0000_0006, 32'h0000_0007, 1'b0},
  '{alu_pkg::op_mul,  1'b0, 32'hffff_fffd, 32'h0000_0005, 1'b0},
  '{alu_pkg::op_mul,  1'b0, 32'hffff_fff9, 32'hffff_fff7, 1'b0},
  '{alu_pkg::op_mul,  1'b0, 32'h7fff_ffff, 32'h7fff_ffff, 1'b0},
  '{alu_pkg::op_mul,  1'b0, 32'h8000_0000, 32'h8000_0000, 1'b0},
  '{alu_pkg::op_mul,  1'b0, 32'h8000_0000, 32'hffff_ffff, 1'b0},
  '{alu_pkg::op_div,  1'b0, 32'h0000_0064, 32'h0000_0007, 1'b0},
  '{alu_pkg::op_div,  1'b0, 32'hffff_ff9c, 32'h0000_0007, 1'b0},
  '{alu_pkg::op_div,  1'b0, 32'h0000_0064, 32'hffff_fff9, 1'b0},
  '{alu_pkg::op_div,  1'b0, 32'hffff_ff9c, 32'hffff_fff9, 1'b0},
  '{alu_pkg::op_div,  1'b0, 32'h8000_0000, 32'hffff_ffff, 1'b0},
  '{alu_pkg::op_div,  1'b0, 32'h0000_0005, 32'h0000_0000, 1'b0},
  '{alu_pkg::op_div,  1'b0, 32'hffff_fffb, 32'h0000_0000, 1'b0},
  '{alu_pkg::op_div,  1'b0, 32'h0000_03e8, 32'h0000_0003, 1'b0},
  '{alu_pkg::op_div,  1'b0, 32'h0000_0064, 32'h0000_0009, 1'b1}, // Would restart the divider
  '{alu_pkg::op_add,  1'b1, 32'h0000_0100, 32'h0000_0055, 1'b0},
  '{alu_pkg::op_mul,  1'b1, 32'h0000_0200, 32'h0000_0007, 1'b0},
  '{alu_pkg::op_div,  1'b1, 32'hffff_ffff, 32'h0000_0000, 1'b0},
  '{alu_pkg::op_nop,  1'b0, 32'h1234_5678, 32'h0000_5678, 1'b0},
  '{5'b11111,         1'b0, 32'hdead_beef, 32'h0000_0003, 1'b0},
  '{5'b00000,         1'b0, 32'hcafe_f00d, 32'h0000_0001, 1'b0}
};

`endif

/* sim/tb_alu_unit.sv */
`default_nettype none

module tb_alu_unit;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_RANDOM = 40;
  localparam int ROW_TIMEOUT = 100;

  typedef struct packed {
    logic [4:0]  op;
    logic        inc_pc;
    logic [31:0] a;
    logic [31:0] b;
    logic        expect_ignore;
  } vec_t;

  `include "alu_vectors.svh"

  localparam logic [4:0] RANDOM_OPS [14] = '{
    alu_pkg::op_add, alu_pkg::op_sub, alu_pkg::op_shr, alu_pkg::op_shra,
    alu_pkg::op_shl, alu_pkg::op_ror, alu_pkg::op_rol, alu_pkg::op_and,
    alu_pkg::op_or, alu_pkg::op_mul, alu_pkg::op_div, alu_pkg::op_neg,
    alu_pkg::op_not, alu_pkg::op_nop
  };

  logic                 clock;
  logic                 reset;
  logic                 start;
  alu_pkg::alu_req_t    req;
  logic                 busy;
  logic                 done;
  alu_pkg::alu_result_t result;

  vec_t rows[$];
  int   seed;
  int   errors = 0;
  int   tests_run = 0;
  int   tests_failed = 0;
  int   done_count = 0;
  int   expected_dones = 0;
  bit   rows_ready = 1'b0;
  bit   timed_out = 1'b0;

  alu_unit u_alu_unit (
    .clock(clock), .reset(reset), .start(start), .req(req),
    .busy(busy), .done(done), .result(result)
  );

  always #10 clock = ~clock;

  always @(posedge clock) begin
    if (!reset && done) begin
      done_count <= done_count + 1;
    end
  end

  function automatic alu_pkg::alu_req_t to_req(vec_t v);
    alu_pkg::alu_req_t r;
    r.op     = alu_pkg::alu_op_e'(v.op);
    r.inc_pc = v.inc_pc;
    r.a      = v.a;
    r.b      = v.b;
    return r;
  endfunction

  function automatic logic [63:0] expected_result(vec_t v);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [63:0] t;
    logic signed [63:0] q;
    logic signed [63:0] r;
    logic [63:0]        both;
    logic [4:0]         amt;
    logic [63:0]        res;
    sa   = {{32{v.a[31]}}, v.a};
    sb   = {{32{v.b[31]}}, v.b};
    both = {v.a, v.a}; // Doubled word for rotates
    amt  = v.b[4:0];
    res  = '0;
    if (v.inc_pc) begin
      res[31:0] = v.a + 32'd1;
    end else begin
      case (v.op)
        alu_pkg::op_add: res[31:0] = v.a + v.b;
        alu_pkg::op_sub: res[31:0] = v.a - v.b;
        alu_pkg::op_and: res[31:0] = v.a & v.b;
        alu_pkg::op_or:  res[31:0] = v.a | v.b;
        alu_pkg::op_neg: res[31:0] = -v.b;
        alu_pkg::op_not: res[31:0] = ~v.b;
        alu_pkg::op_shr: res[31:0] = v.a >> amt;
        alu_pkg::op_shl: res[31:0] = v.a << amt;
        alu_pkg::op_shra: begin
          t = sa >>> amt;
          res[31:0] = t[31:0];
        end
        alu_pkg::op_ror: begin
          t = both >> amt;
          res[31:0] = t[31:0];
        end
        alu_pkg::op_rol: begin
          t = both << amt;
          res[31:0] = t[63:32];
        end
        alu_pkg::op_mul: res = sa * sb;
        alu_pkg::op_div: begin
          if (v.b == 32'd0) begin
            res = {v.a, 32'hffff_ffff};
          end else begin
            q = sa / sb;
            r = sa % sb; // Sign follows a
            res = {r[31:0], q[31:0]};
          end
        end
        default: res = '0;
      endcase
    end
    return res;
  endfunction

  function automatic int expected_latency(vec_t v);
    if (v.inc_pc) begin
      return 1;
    end
    if (v.op == alu_pkg::op_mul) begin
      return 18;
    end
    if (v.op == alu_pkg::op_div) begin
      return 34;
    end
    return 1;
  endfunction

  task automatic run_request(input int idx);
    vec_t        v;
    vec_t        intruder;
    bit          has_intruder;
    logic [63:0] exp;
    logic [63:0] got;
    int          lat;
    int          cycles;
    bit          seen;
    bit          ok;
    v = rows[idx];
    intruder = '0;
    has_intruder = (idx + 1 < rows.size()) && rows[idx + 1].expect_ignore;
    if (has_intruder) begin
      intruder = rows[idx + 1];
    end
    exp = expected_result(v);
    lat = expected_latency(v);
    ok = 1'b1;
    seen = 1'b0;
    cycles = 0;
    tests_run++;
    req = to_req(v);
    start = 1'b1;
    @(posedge clock); // Accepting edge
    #2;
    start = 1'b0;
    while (!seen && cycles < ROW_TIMEOUT) begin
      @(posedge clock);
      #1;
      cycles++;
      if (done) begin
        seen = 1'b1;
      end
      if (busy !== (!done && lat > 1)) begin
        $display("[ERROR] t=%0t test %0d: busy=%b after %0d clocks", $time, idx, busy, cycles);
        errors++;
        ok = 1'b0;
      end
      if (has_intruder && cycles == 5) begin
        #1;
        if (busy !== 1'b1) begin
          $display("Test %0d could not pulse the extra start, the unit was not busy", idx);
          errors++;
          ok = 1'b0;
        end
        req = to_req(intruder);
        start = 1'b1;
      end else if (has_intruder && cycles == 6) begin
        #1;
        start = 1'b0;
      end
    end
    if (!seen) begin
      $display("Test %0d timed out, done never came within %0d clocks", idx, ROW_TIMEOUT);
      errors++;
      tests_failed++;
      timed_out = 1'b1;
      return;
    end
    got = result;
    if (cycles != lat) begin
      $display("[ERROR] t=%0t test %0d: done after %0d clocks, expected %0d",
               $time, idx, cycles, lat);
      errors++;
      ok = 1'b0;
    end
    if (got !== exp) begin
      $display("[ERROR] t=%0t test %0d: result %h, expected %h", $time, idx, got, exp);
      errors++;
      ok = 1'b0;
    end
    expected_dones++;
    @(posedge clock);
    @(posedge clock);
    #1;
    if (done_count != expected_dones || done !== 1'b0) begin
      $display("[ERROR] t=%0t test %0d: %0d done pulses seen, expected %0d",
               $time, idx, done_count, expected_dones);
      errors++;
      ok = 1'b0;
    end
    if (!ok) begin
      tests_failed++;
    end
    $display("test %0d op=%b inc_pc=%0d a=%h b=%h result=%h clocks=%0d %s",
             idx, v.op, v.inc_pc, v.a, v.b, got, cycles, ok ? "ok" : "FAIL");
    #1;
  endtask

  // Nothing may follow the extra start pulsed by the row before
  task automatic check_ignored(input int idx);
    logic [63:0] prev;
    bit          ok;
    prev = result;
    ok = 1'b1;
    tests_run++;
    repeat (20) @(posedge clock);
    #1;
    if (done_count != expected_dones || busy !== 1'b0 || result !== prev) begin
      $display("[ERROR] t=%0t test %0d: start while busy was not ignored", $time, idx);
      errors++;
      ok = 1'b0;
      tests_failed++;
    end
    $display("test %0d start while busy ignored %s", idx, ok ? "ok" : "FAIL");
    #1;
  endtask

  initial begin
    int watchdog_ns;
    wait (rows_ready);
    watchdog_ns = (rows.size() + 1) * 40 * 20;
    #(watchdog_ns);
    $display("Watchdog expired after %0d ns, the run hung", watchdog_ns);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    int unsigned pick;
    vec_t        v;
    clock = 1'b0;
    reset = 1'b1;
    start = 1'b0;
    req   = '0;
    seed  = 32'he779_85ac;
    foreach (DIRECTED[i]) begin
      rows.push_back(DIRECTED[i]);
    end
    for (int i = 0; i < N_RANDOM; i++) begin
      pick = $unsigned($random(seed)) % 14;
      v.op = RANDOM_OPS[pick];
      v.inc_pc = (($random(seed) & 15) == 0);
      v.a = $random(seed);
      v.b = $random(seed);
      v.expect_ignore = 1'b0;
      rows.push_back(v);
    end
    rows_ready = 1'b1;

    repeat (4) @(posedge clock);
    #2;
    reset = 1'b0;
    @(posedge clock);
    #1;
    tests_run++;
    if (busy !== 1'b0 || done !== 1'b0 || result !== '0) begin
      $display("[ERROR] t=%0t reset: busy=%b done=%b result=%h", $time, busy, done, result);
      errors++;
      tests_failed++;
    end
    $display("test reset busy=%b done=%b result=%h", busy, done, result);
    #1;

    for (int i = 0; i < rows.size() && !timed_out; i++) begin
      if (rows[i].expect_ignore) begin
        check_ignored(i);
      end else begin
        run_request(i);
      end
    end

    $display("Summary: %0d tests run, %0d failed, %0d check errors",
             tests_run, tests_failed, errors);
    if (errors == 0 && !timed_out) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/alu_unit.sv */
`default_nettype none

module alu_unit (
  input  wire logic                  clock,
  input  wire logic                  reset,
  input  wire logic                  start,
  input  wire alu_pkg::alu_req_t     req,
  output logic                       busy,
  output logic                       done,
  output alu_pkg::alu_result_t       result
);

  typedef enum logic [1:0] {st_idle, st_wait_mul, st_wait_div} state_e;

  state_e                          state;
  alu_pkg::alu_req_t               req_q;
  logic                            pend_q;
  logic                            accept;
  logic                            mul_start, mul_done;
  logic                            div_start, div_done;
  logic [alu_pkg::DATA_W-1:0]      and_out, or_out, add_out, sub_out;
  logic [alu_pkg::DATA_W-1:0]      neg_out, not_out, inc_out, shift_out;
  logic [alu_pkg::DATA_W-1:0]      quotient, remainder;
  logic [alu_pkg::RESULT_W-1:0]    product;
  alu_pkg::shift_op_e              shift_sel;
  alu_pkg::alu_result_t            single_val;

  assign busy = (state != st_idle);
  assign accept = start && !busy; // Starts while busy are dropped

  assign mul_start = pend_q && !req_q.inc_pc && (req_q.op == alu_pkg::op_mul);
  assign div_start = pend_q && !req_q.inc_pc && (req_q.op == alu_pkg::op_div);

  always_comb begin
    case (req_q.op)
      alu_pkg::op_shra: shift_sel = alu_pkg::sh_shra;
      alu_pkg::op_shl:  shift_sel = alu_pkg::sh_shl;
      alu_pkg::op_ror:  shift_sel = alu_pkg::sh_ror;
      alu_pkg::op_rol:  shift_sel = alu_pkg::sh_rol;
      default:          shift_sel = alu_pkg::sh_shr;
    endcase
  end

  always_comb begin
    single_val = '0; // hi stays zero for word ops
    if (req_q.inc_pc) begin
      single_val.lo = inc_out;
    end else begin
      case (req_q.op)
        alu_pkg::op_and:  single_val.lo = and_out;
        alu_pkg::op_or:   single_val.lo = or_out;
        alu_pkg::op_add:  single_val.lo = add_out;
        alu_pkg::op_sub:  single_val.lo = sub_out;
        alu_pkg::op_neg:  single_val.lo = neg_out;
        alu_pkg::op_not:  single_val.lo = not_out;
        alu_pkg::op_shr, alu_pkg::op_shra, alu_pkg::op_shl,
        alu_pkg::op_ror, alu_pkg::op_rol: single_val.lo = shift_out;
        default:          single_val.lo = '0; // nop and undefined codes
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      req_q <= req;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state  <= st_idle;
      pend_q <= 1'b0;
      done   <= 1'b0;
      result <= '0;
    end else begin
      pend_q <= accept;
      done   <= 1'b0;
      case (state)
        st_idle: begin
          if (mul_start) begin
            state <= st_wait_mul;
          end else if (div_start) begin
            state <= st_wait_div;
          end else if (pend_q) begin
            done   <= 1'b1;
            result <= single_val;
          end
        end
        st_wait_mul: begin
          if (mul_done) begin
            done   <= 1'b1;
            result <= alu_pkg::alu_result_t'(product);
            state  <= st_idle;
          end
        end
        st_wait_div: begin
          if (div_done) begin
            done      <= 1'b1;
            result.hi <= remainder;
            result.lo <= quotient;
            state     <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  alu_logic_arith u_logic_arith (
    .a(req_q.a), .b(req_q.b),
    .and_out(and_out), .or_out(or_out), .add_out(add_out), .sub_out(sub_out),
    .neg_out(neg_out), .not_out(not_out), .inc_out(inc_out)
  );

  alu_shifter u_shifter (
    .a(req_q.a), .amount(req_q.b[4:0]), .sel(shift_sel), .shift_out(shift_out)
  );

  alu_booth_mul u_booth_mul (
    .clock(clock), .reset(reset), .start(mul_start),
    .multiplicand(req_q.a), .multiplier(req_q.b),
    .done(mul_done), .product(product)
  );

  alu_divider u_divider (
    .clock(clock), .reset(reset), .start(div_start),
    .dividend(req_q.a), .divisor(req_q.b),
    .done(div_done), .quotient(quotient), .remainder(remainder)
  );

endmodule

`default_nettype wire
